//--- vlog.f
+incdir+bench
src/alpha_decode_pkg.sv
src/inst_decoder.sv
src/id_stage.sv
src/id_ex_latch.sv
src/decode_top.sv
bench/tb_decode_top.sv

//--- Bender.yml
package:
  name: alpha_decode

sources:
  - src/alpha_decode_pkg.sv
  - src/inst_decoder.sv
  - src/id_stage.sv
  - src/id_ex_latch.sv
  - src/decode_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_decode_top.sv

//--- bench/decode_vectors.svh
// expected fields follow the decode rules; the noop rows still carry their word in ir
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// flag vector, msb first: rd wr ldl stc cond uncond halt cpuid illegal valid_inst
localparam logic [9:0] F_RD = 10'h200;
localparam logic [9:0] F_WR = 10'h100;
localparam logic [9:0] F_LDL = 10'h080;
localparam logic [9:0] F_STC = 10'h040;
localparam logic [9:0] F_CND = 10'h020;
localparam logic [9:0] F_UNC = 10'h010;
localparam logic [9:0] F_HLT = 10'h008;
localparam logic [9:0] F_CPU = 10'h004;
localparam logic [9:0] F_ILL = 10'h002;
localparam logic [9:0] F_VLD = 10'h001;

typedef struct packed {
	logic [31:0] word;	// instruction from fetch
	logic valid;
	logic [4:0] ra_idx;
	logic [4:0] rb_idx;
	logic [4:0] dest_idx;
	logic [2:0] fu_sel;
	logic [4:0] alu_func;
	logic [9:0] flags;	// order as above
} vec_row_t;

// ******************************
// encoders, one per format
// ******************************
function automatic logic [31:0] op_word(input logic [5:0] opc, input logic [4:0] ra,
	input logic [4:0] rb, input logic [6:0] func, input logic [4:0] rc);
	op_word = {opc, ra, rb, 3'b000, 1'b0, func, rc};	// register form, sbz bits clear
endfunction

function automatic logic [31:0] lit_word(input logic [5:0] opc, input logic [4:0] ra,
	input logic [7:0] lit, input logic [6:0] func, input logic [4:0] rc);
	lit_word = {opc, ra, lit, 1'b1, func, rc};	// literal sits over rb
endfunction

function automatic logic [31:0] mem_word(input logic [5:0] opc, input logic [4:0] ra,
	input logic [4:0] rb, input logic [15:0] disp);
	mem_word = {opc, ra, rb, disp};
endfunction

function automatic logic [31:0] br_word(input logic [5:0] opc, input logic [4:0] ra,
	input logic [20:0] disp);
	br_word = {opc, ra, disp};
endfunction

function automatic logic [31:0] pal_word(input logic [25:0] func);
	pal_word = {alpha_decode_pkg::PAL_INST, func};
endfunction

localparam int NUM_VEC = 19;

// word, valid, ra, rb, dest, unit, function, flags
localparam vec_row_t VEC_TABLE [NUM_VEC] = '{
	'{op_word(alpha_decode_pkg::INTA_GRP, 5'd1, 5'd2, alpha_decode_pkg::ADDQ, 5'd3), 1'b1,
		5'd1, 5'd2, 5'd3, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_ADDQ, F_VLD},
	'{lit_word(alpha_decode_pkg::INTA_GRP, 5'd4, 8'h15, alpha_decode_pkg::ADDQ, 5'd5), 1'b1,
		5'd4, 5'd31, 5'd5, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_ADDQ, F_VLD},
	'{op_word(alpha_decode_pkg::INTA_GRP, 5'd6, 5'd7, alpha_decode_pkg::CMPULT, 5'd8), 1'b1,
		5'd6, 5'd7, 5'd8, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_CMPULT, F_VLD},
	'{op_word(alpha_decode_pkg::INTL_GRP, 5'd9, 5'd10, alpha_decode_pkg::BIS, 5'd11), 1'b1,
		5'd9, 5'd10, 5'd11, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_BIS, F_VLD},
	'{op_word(alpha_decode_pkg::INTS_GRP, 5'd12, 5'd13, alpha_decode_pkg::SRA, 5'd14), 1'b1,
		5'd12, 5'd13, 5'd14, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_SRA, F_VLD},
	'{op_word(alpha_decode_pkg::INTM_GRP, 5'd15, 5'd16, alpha_decode_pkg::MULQ, 5'd17), 1'b1,
		5'd15, 5'd16, 5'd17, alpha_decode_pkg::FU_MULT, alpha_decode_pkg::ALU_MULQ, F_VLD},
	'{mem_word(alpha_decode_pkg::LDA_INST, 5'd18, 5'd19, 16'h0040), 1'b1,
		5'd31, 5'd19, 5'd18, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_ADDQ, F_VLD},
	'{mem_word(alpha_decode_pkg::LDQ_INST, 5'd20, 5'd21, 16'h0008), 1'b1,
		5'd31, 5'd21, 5'd20, alpha_decode_pkg::FU_LOAD, alpha_decode_pkg::ALU_ADDQ, F_RD | F_VLD},
	'{mem_word(alpha_decode_pkg::LDQ_L_INST, 5'd22, 5'd23, 16'h0010), 1'b1, 5'd31, 5'd23, 5'd22,
		alpha_decode_pkg::FU_LOAD, alpha_decode_pkg::ALU_ADDQ, F_RD | F_LDL | F_VLD},
	'{mem_word(alpha_decode_pkg::STQ_INST, 5'd24, 5'd25, 16'hfff8), 1'b1,
		5'd31, 5'd25, 5'd31, alpha_decode_pkg::FU_STORE, alpha_decode_pkg::ALU_ADDQ, F_WR | F_VLD},
	'{mem_word(alpha_decode_pkg::STQ_C_INST, 5'd26, 5'd27, 16'h0000), 1'b1, 5'd31, 5'd27, 5'd26,
		alpha_decode_pkg::FU_STORE, alpha_decode_pkg::ALU_ADDQ, F_WR | F_STC | F_VLD},
	'{br_word(alpha_decode_pkg::BR_INST, 5'd28, 21'h000100), 1'b1, 5'd28, 5'd31, 5'd28,
		alpha_decode_pkg::FU_UNCOND_BRANCH, alpha_decode_pkg::ALU_ADDQ, F_UNC | F_VLD},
	'{br_word(alpha_decode_pkg::BSR_INST, 5'd26, 21'h1ffff0), 1'b1, 5'd26, 5'd31, 5'd26,
		alpha_decode_pkg::FU_UNCOND_BRANCH, alpha_decode_pkg::ALU_ADDQ, F_UNC | F_VLD},
	'{br_word(6'h39, 5'd5, 21'h000010), 1'b1, 5'd5, 5'd31, 5'd31,	// beq
		alpha_decode_pkg::FU_COND_BRANCH, alpha_decode_pkg::ALU_ADDQ, F_CND | F_VLD},
	'{mem_word(alpha_decode_pkg::JSR_GRP, 5'd26, 5'd27, 16'h4000), 1'b1, 5'd31, 5'd27, 5'd26,
		alpha_decode_pkg::FU_UNCOND_BRANCH, alpha_decode_pkg::ALU_AND, F_UNC | F_VLD},
	'{pal_word(alpha_decode_pkg::PAL_WHAMI), 1'b1, 5'd31, 5'd31, 5'd0,	// ra field is zero
		alpha_decode_pkg::FU_NONE, alpha_decode_pkg::ALU_ADDQ, F_CPU | F_VLD},
	'{br_word(alpha_decode_pkg::FBNE, 5'd3, 21'h000020), 1'b1, 5'd3, 5'd31, 5'd31,
		alpha_decode_pkg::FU_NONE, alpha_decode_pkg::ALU_ADDQ, F_ILL},
	'{op_word(alpha_decode_pkg::INTA_GRP, 5'd1, 5'd2, 7'h7f, 5'd3), 1'b1,	// unknown func
		5'd1, 5'd2, 5'd3, alpha_decode_pkg::FU_ALU, alpha_decode_pkg::ALU_ADDQ, F_ILL},
	'{op_word(alpha_decode_pkg::INTA_GRP, 5'd1, 5'd2, alpha_decode_pkg::ADDQ, 5'd3), 1'b0,
		5'd31, 5'd31, 5'd31, alpha_decode_pkg::FU_NONE, alpha_decode_pkg::ALU_ADDQ, 10'h000}
};

`endif

//--- bench/tb_decode_top.sv
// drives on falling edges and checks at the next falling edge, one packet per cycle, no handshake
`default_nettype none
`timescale 1ns/1ns

module tb_decode_top;

	`include "decode_vectors.svh"

	localparam int NUM_RAND = 200;
	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_CYCLES = 40;	// two resets, stall, flush, halt
	localparam int MAX_CYCLES = 2 * (NUM_VEC + NUM_RAND + DIRECTED_CYCLES);

	localparam vec_row_t HALT_ROW = '{pal_word(alpha_decode_pkg::PAL_HALT), 1'b1, 5'd31, 5'd31,
		5'd31, alpha_decode_pkg::FU_NONE, alpha_decode_pkg::ALU_ADDQ, F_HLT | F_VLD};
	localparam logic [5:0] OPC_POOL [16] = '{alpha_decode_pkg::INTA_GRP,
		alpha_decode_pkg::INTL_GRP, alpha_decode_pkg::INTS_GRP, alpha_decode_pkg::INTM_GRP,
		alpha_decode_pkg::JSR_GRP, alpha_decode_pkg::LDA_INST, alpha_decode_pkg::LDQ_INST,
		alpha_decode_pkg::LDQ_L_INST, alpha_decode_pkg::STQ_INST, alpha_decode_pkg::STQ_C_INST,
		alpha_decode_pkg::BR_INST, alpha_decode_pkg::BSR_INST, 6'h39, 6'h3d,
		alpha_decode_pkg::FBNE, alpha_decode_pkg::PAL_INST};	// biased opcode picks

	logic clk;
	logic reset_i;
	alpha_decode_pkg::alpha_inst_u inst_i;
	logic inst_valid_i;
	logic stall_i;
	logic flush_i;
	alpha_decode_pkg::id_packet_t id_ex_o;
	logic halted_o;
	logic [alpha_decode_pkg::VCOUNT_W-1:0] valid_count_o;
	logic [31:0] lcg_state = 32'd26641;	// seed
	int cycle_count = 0;
	int exp_count = 0;	// valid instructions the latch should have taken

	decode_top dut0 (
		.clk(clk),
		.reset_i(reset_i),
		.inst_i(inst_i),
		.inst_valid_i(inst_valid_i),
		.stall_i(stall_i),
		.flush_i(flush_i),
		.id_ex_o(id_ex_o),
		.halted_o(halted_o),
		.valid_count_o(valid_count_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			fail_run($sformatf("timeout, the run went past %0d cycles", MAX_CYCLES));
	end

	// ******************************
	// reporting and checks
	// ******************************
	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_field(input string name, input logic [95:0] got, input logic [95:0] exp);
		assert (got === exp)
		else
			fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [9:0] flags_of(input alpha_decode_pkg::id_packet_t p);
		flags_of = {p.rd_mem, p.wr_mem, p.ldl_mem, p.stc_mem, p.cond_branch,
			p.uncond_branch, p.halt, p.cpuid, p.illegal, p.valid_inst};
	endfunction

	task automatic compare_row(input vec_row_t row);
		check_field("id_ex_o.ir", id_ex_o.ir, row.word);
		check_field("id_ex_o.ra_idx", id_ex_o.ra_idx, row.ra_idx);
		check_field("id_ex_o.rb_idx", id_ex_o.rb_idx, row.rb_idx);
		check_field("id_ex_o.dest_idx", id_ex_o.dest_idx, row.dest_idx);
		check_field("id_ex_o.fu_sel", id_ex_o.fu_sel, row.fu_sel);
		check_field("id_ex_o.alu_func", id_ex_o.alu_func, row.alu_func);
		check_field("id_ex_o flags", flags_of(id_ex_o), row.flags);
	endtask

	// bubble: word cleared, r31 everywhere, nothing flagged
	task automatic expect_noop();
		compare_row('{32'h0, 1'b0, 5'd31, 5'd31, 5'd31, alpha_decode_pkg::FU_NONE,
			alpha_decode_pkg::ALU_ADDQ, 10'h000});
	endtask

	task automatic verify_count();
		check_field("valid_count_o", valid_count_o, exp_count[alpha_decode_pkg::VCOUNT_W-1:0]);
	endtask

	// ******************************
	// reference for random words
	// ******************************
	function automatic logic is_legal(input logic [31:0] word);
		logic [5:0] opc;
		logic [6:0] func;
		opc = word[31:26];
		func = word[11:5];
		case (opc)
			alpha_decode_pkg::PAL_INST: is_legal = (word[25:0] == alpha_decode_pkg::PAL_WHAMI) ||
				(word[25:0] == alpha_decode_pkg::PAL_HALT);
			alpha_decode_pkg::INTA_GRP: is_legal = func inside {alpha_decode_pkg::ADDQ,
				alpha_decode_pkg::SUBQ, alpha_decode_pkg::CMPEQ, alpha_decode_pkg::CMPLT,
				alpha_decode_pkg::CMPLE, alpha_decode_pkg::CMPULT, alpha_decode_pkg::CMPULE};
			alpha_decode_pkg::INTL_GRP: is_legal = func inside {alpha_decode_pkg::AND,
				alpha_decode_pkg::BIC, alpha_decode_pkg::BIS, alpha_decode_pkg::ORNOT,
				alpha_decode_pkg::XOR, alpha_decode_pkg::EQV};
			alpha_decode_pkg::INTS_GRP: is_legal = func inside {alpha_decode_pkg::SRL,
				alpha_decode_pkg::SLL, alpha_decode_pkg::SRA};
			alpha_decode_pkg::INTM_GRP: is_legal = (func == alpha_decode_pkg::MULQ);
			alpha_decode_pkg::JSR_GRP, alpha_decode_pkg::LDA_INST, alpha_decode_pkg::LDQ_INST,
			alpha_decode_pkg::LDQ_L_INST, alpha_decode_pkg::STQ_INST, alpha_decode_pkg::STQ_C_INST:
				is_legal = 1'b1;
			alpha_decode_pkg::FBEQ, alpha_decode_pkg::FBLT, alpha_decode_pkg::FBLE,
			alpha_decode_pkg::FBNE, alpha_decode_pkg::FBGE, alpha_decode_pkg::FBGT:
				is_legal = 1'b0;	// fp branches
			default: is_legal = (opc[5:4] == 2'b11);	// integer branch block
		endcase
	endfunction

	// indices and flags of a legal word, unit and function left out
	function automatic vec_row_t model_row(input logic [31:0] word);
		vec_row_t r;
		logic [5:0] opc;
		opc = word[31:26];
		r = '{word, 1'b1, 5'd31, 5'd31, 5'd31, alpha_decode_pkg::FU_NONE,
			alpha_decode_pkg::ALU_ADDQ, F_VLD};
		if (opc inside {alpha_decode_pkg::INTA_GRP, alpha_decode_pkg::INTL_GRP,
			alpha_decode_pkg::INTS_GRP, alpha_decode_pkg::INTM_GRP})
		begin
			r.ra_idx = word[25:21];
			r.rb_idx = word[12] ? 5'd31 : word[20:16];	// literal replaces rb
			r.dest_idx = word[4:0];
		end
		else if (opc[5:4] == 2'b11)
		begin
			r.ra_idx = word[25:21];	// tested or linked
			if (opc == alpha_decode_pkg::BR_INST || opc == alpha_decode_pkg::BSR_INST)
			begin
				r.dest_idx = word[25:21];
				r.flags |= F_UNC;
			end
			else
				r.flags |= F_CND;
		end
		else if (opc == alpha_decode_pkg::JSR_GRP)
		begin
			r.rb_idx = word[20:16];	// jump target
			r.dest_idx = word[25:21];
			r.flags |= F_UNC;
		end
		else if (opc == alpha_decode_pkg::PAL_INST)
		begin
			if (word[25:0] == alpha_decode_pkg::PAL_WHAMI)
			begin
				r.dest_idx = word[25:21];
				r.flags |= F_CPU;
			end
			else
				r.flags |= F_HLT;
		end
		else
		begin
			r.rb_idx = word[20:16];	// base register
			r.dest_idx = (opc == alpha_decode_pkg::STQ_INST) ? 5'd31 : word[25:21];
			case (opc)
				alpha_decode_pkg::LDQ_INST: r.flags |= F_RD;
				alpha_decode_pkg::LDQ_L_INST: r.flags |= F_RD | F_LDL;
				alpha_decode_pkg::STQ_INST: r.flags |= F_WR;
				alpha_decode_pkg::STQ_C_INST: r.flags |= F_WR | F_STC;
				default: r.flags |= 10'h000;	// lda, address only
			endcase
		end
		model_row = r;
	endfunction

	task automatic score_random(input logic [31:0] word, input logic valid);
		vec_row_t exp;
		assert (!(id_ex_o.illegal && id_ex_o.valid_inst))
		else
			fail_run("an illegal instruction came out with valid_inst set");
		if (!valid)
			compare_row('{word, 1'b0, 5'd31, 5'd31, 5'd31, alpha_decode_pkg::FU_NONE,
				alpha_decode_pkg::ALU_ADDQ, 10'h000});
		else if (!is_legal(word))
		begin
			check_field("id_ex_o.ir", id_ex_o.ir, word);
			check_field("id_ex_o.illegal", id_ex_o.illegal, 1'b1);
			check_field("id_ex_o.valid_inst", id_ex_o.valid_inst, 1'b0);
		end
		else
		begin
			exp = model_row(word);
			check_field("id_ex_o.ir", id_ex_o.ir, word);
			check_field("id_ex_o.ra_idx", id_ex_o.ra_idx, exp.ra_idx);
			check_field("id_ex_o.rb_idx", id_ex_o.rb_idx, exp.rb_idx);
			check_field("id_ex_o.dest_idx", id_ex_o.dest_idx, exp.dest_idx);
			check_field("id_ex_o flags", flags_of(id_ex_o), exp.flags);
		end
	endtask

	// ******************************
	// stimulus helpers
	// ******************************
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		next_random = lcg_state;
	endfunction

	task automatic step();
		@(posedge clk);	// latch samples
		@(negedge clk);	// outputs settled, next drive point
	endtask

	task automatic drive(input logic [31:0] word, input logic valid);
		inst_i = word;
		inst_valid_i = valid;
	endtask

	task automatic apply_reset();
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		exp_count = 0;
		expect_noop();
		check_field("halted_o", halted_o, 1'b0);
		verify_count();
	endtask

	initial
	begin
		alpha_decode_pkg::id_packet_t held;
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		logic [31:0] r_ctl;
		logic [31:0] word;
		logic valid;
		inst_i = '0;
		inst_valid_i = 1'b0;
		stall_i = 1'b0;
		flush_i = 1'b0;
		reset_i = 1'b1;
		apply_reset();

		// table, one row per cycle
		for (int i = 0; i < NUM_VEC; i++)
		begin
			drive(VEC_TABLE[i].word, VEC_TABLE[i].valid);
			step();
			compare_row(VEC_TABLE[i]);
			if (VEC_TABLE[i].valid && (VEC_TABLE[i].flags & F_ILL) == 10'h000)
				exp_count++;
		end
		verify_count();

		// stall hold while fetch keeps changing the word
		drive(VEC_TABLE[0].word, 1'b1);
		step();
		exp_count++;
		held = id_ex_o;
		stall_i = 1'b1;
		for (int i = 1; i <= 4; i++)
		begin
			drive(VEC_TABLE[i].word, 1'b1);
			step();
			check_field("id_ex_o", id_ex_o, held);
			verify_count();
		end
		stall_i = 1'b0;	// row 4 still presented
		step();
		compare_row(VEC_TABLE[4]);
		exp_count++;
		verify_count();

		// flush alone, then flush over stall
		drive(VEC_TABLE[5].word, 1'b1);
		flush_i = 1'b1;
		step();
		flush_i = 1'b0;
		expect_noop();
		verify_count();
		step();	// row 5 taken once flush drops
		compare_row(VEC_TABLE[5]);
		exp_count++;
		verify_count();
		stall_i = 1'b1;
		flush_i = 1'b1;
		drive(VEC_TABLE[6].word, 1'b1);
		step();
		flush_i = 1'b0;
		expect_noop();
		step();
		expect_noop();	// stall keeps the bubble
		verify_count();
		stall_i = 1'b0;
		step();
		compare_row(VEC_TABLE[6]);
		exp_count++;
		verify_count();

		// random words, halt kept out
		for (int n = 0; n < NUM_RAND; n++)
		begin
			r_hi = next_random();
			r_lo = next_random();
			r_ctl = next_random();
			word = {r_hi[31:16], r_lo[31:16]};
			if (r_ctl[20])
				word[31:26] = OPC_POOL[r_ctl[19:16]];
			if (r_ctl[21])
				word[11:5] = alpha_decode_pkg::ADDQ;	// same code as bis and mulq
			if (word[31:26] == alpha_decode_pkg::PAL_INST && r_ctl[22])
				word[25:0] = alpha_decode_pkg::PAL_WHAMI;
			if (word[31:26] == alpha_decode_pkg::PAL_INST && word[25:0] == alpha_decode_pkg::PAL_HALT)
				word[0] = ~word[0];
			valid = r_ctl[23] | r_ctl[24];	// mostly valid
			drive(word, valid);
			step();
			score_random(word, valid);
			if (valid && is_legal(word))
				exp_count++;
		end
		verify_count();

		// halt lock until reset
		drive(HALT_ROW.word, 1'b1);
		step();
		compare_row(HALT_ROW);
		check_field("halted_o", halted_o, 1'b1);
		exp_count++;
		verify_count();
		for (int i = 0; i < 3; i++)
		begin
			drive(VEC_TABLE[0].word, 1'b1);
			step();
			expect_noop();
			check_field("halted_o", halted_o, 1'b1);
			verify_count();
		end
		apply_reset();
		step();	// addq still presented
		compare_row(VEC_TABLE[0]);
		exp_count++;
		verify_count();

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/decode_top.sv
// one cycle from inst_i to id_ex_o, with stall and flush sampled on the same edge as the word
`default_nettype none
`timescale 1ns/1ns

module decode_top (
	input logic clk,
	input logic reset_i,	// sync, active high
	input alpha_decode_pkg::alpha_inst_u inst_i,	// from fetch
	input logic inst_valid_i,
	input logic stall_i,	// back-pressure level
	input logic flush_i,	// one cycle pulse
	output alpha_decode_pkg::id_packet_t id_ex_o,
	output logic halted_o,
	output logic [alpha_decode_pkg::VCOUNT_W-1:0] valid_count_o
);

	alpha_decode_pkg::id_packet_t id_packet;	// decode result, comb

	// ******************************
	// decode
	// ******************************
	id_stage id_stage0 (
		.inst_i(inst_i),
		.inst_valid_i(inst_valid_i),
		.id_packet_o(id_packet)
	);

	// ******************************
	// id/ex register
	// ******************************
	id_ex_latch id_ex_latch0 (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_i),
		.flush_i(flush_i),
		.id_packet_i(id_packet),
		.id_ex_o(id_ex_o),
		.halted_o(halted_o),
		.valid_count_o(valid_count_o)
	);

endmodule

`default_nettype wire

//--- src/id_ex_latch.sv
// a stalled input is not taken so fetch must hold it, and only reset releases the halt lock
`default_nettype none
`timescale 1ns/1ns

module id_ex_latch (
	input logic clk,
	input logic reset_i,	// sync, active high
	input logic stall_i,	// level, hold register
	input logic flush_i,	// pulse, beats stall
	input alpha_decode_pkg::id_packet_t id_packet_i,
	output alpha_decode_pkg::id_packet_t id_ex_o,
	output logic halted_o,
	output logic [alpha_decode_pkg::VCOUNT_W-1:0] valid_count_o
);

	alpha_decode_pkg::id_packet_t id_ex_q;
	logic halted_q;	// halt lock
	logic [alpha_decode_pkg::VCOUNT_W-1:0] count_q;
	logic load;	// register updates this edge
	logic take;	// incoming packet is accepted

	assign load = flush_i | ~stall_i;
	assign take = ~flush_i & ~stall_i & ~halted_q;	// bubble on flush or once halted

	// ******************************
	// pipeline register
	// ******************************
	always_ff @(posedge clk)
	begin
		if (reset_i)
			id_ex_q <= alpha_decode_pkg::ID_NOOP;
		else if (load)
			id_ex_q <= take ? id_packet_i : alpha_decode_pkg::ID_NOOP;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			halted_q <= 1'b0;
		else if (take & id_packet_i.valid_inst & id_packet_i.halt)
			halted_q <= 1'b1;	// rises with the halt packet
	end

	// retired count wraps silently
	always_ff @(posedge clk)
	begin
		if (reset_i)
			count_q <= '0;
		else if (take & id_packet_i.valid_inst)
			count_q <= count_q + 1'b1;
	end

	assign id_ex_o = id_ex_q;
	assign halted_o = halted_q;
	assign valid_count_o = count_q;

endmodule

`default_nettype wire

//--- src/id_stage.sv
// purely combinational, so the instruction must be stable for the whole cycle it is sampled
`default_nettype none
`timescale 1ns/1ns

module id_stage (
	input alpha_decode_pkg::alpha_inst_u inst_i,
	input logic inst_valid_i,
	output alpha_decode_pkg::id_packet_t id_packet_o
);

	alpha_decode_pkg::dec_ctrl_t ctrl;	// decoder fields
	logic [4:0] ra_fld;
	logic [4:0] rb_fld;
	logic [4:0] rc_fld;

	assign ra_fld = inst_i.op.ra;	// same position in every format
	assign rb_fld = inst_i.op.rb;
	assign rc_fld = inst_i.op.rc;

	inst_decoder decoder0 (
		.inst_i(inst_i),
		.inst_valid_i(inst_valid_i),
		.ctrl_o(ctrl)
	);

	// unused operands point at r31, which never waits on a producer
	always_comb
	begin
		id_packet_o.ra_idx = (ctrl.opa_sel == alpha_decode_pkg::OPA_IS_REGA) ? ra_fld :
			alpha_decode_pkg::ZERO_REG;
		id_packet_o.rb_idx = (ctrl.opb_sel == alpha_decode_pkg::OPB_IS_REGB) ? rb_fld :
			alpha_decode_pkg::ZERO_REG;
		case (ctrl.dest_sel)
			alpha_decode_pkg::DEST_IS_REGC: id_packet_o.dest_idx = rc_fld;	// operate
			alpha_decode_pkg::DEST_IS_REGA: id_packet_o.dest_idx = ra_fld;	// loads, links
			default: id_packet_o.dest_idx = alpha_decode_pkg::ZERO_REG;	// no writeback
		endcase
	end

	assign id_packet_o.ir = inst_i;
	assign id_packet_o.fu_sel = ctrl.fu_sel;
	assign id_packet_o.alu_func = ctrl.alu_func;
	assign id_packet_o.rd_mem = ctrl.rd_mem;
	assign id_packet_o.wr_mem = ctrl.wr_mem;
	assign id_packet_o.ldl_mem = ctrl.ldl_mem;
	assign id_packet_o.stc_mem = ctrl.stc_mem;
	assign id_packet_o.cond_branch = ctrl.cond_branch;
	assign id_packet_o.uncond_branch = ctrl.uncond_branch;
	assign id_packet_o.halt = ctrl.halt;
	assign id_packet_o.cpuid = ctrl.cpuid;
	assign id_packet_o.illegal = ctrl.illegal;
	assign id_packet_o.valid_inst = inst_valid_i & ~ctrl.illegal;	// halt still counts

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
// decodes integer formats only; fp operate, fp branch, misc and unlisted opcodes flag illegal
`default_nettype none
`timescale 1ns/1ns

module inst_decoder (
	input alpha_decode_pkg::alpha_inst_u inst_i,
	input logic inst_valid_i,	// low gives the noop fields
	output alpha_decode_pkg::dec_ctrl_t ctrl_o
);

	always_comb
	begin
		// noop defaults, nothing read or written
		ctrl_o.opa_sel = alpha_decode_pkg::OPA_IS_MEM_DISP;	// not a register read
		ctrl_o.opb_sel = alpha_decode_pkg::OPB_IS_ALU_IMM;	// not a register read
		ctrl_o.dest_sel = alpha_decode_pkg::DEST_NONE;
		ctrl_o.alu_func = alpha_decode_pkg::ALU_ADDQ;	// zero code
		ctrl_o.fu_sel = alpha_decode_pkg::FU_NONE;
		ctrl_o.rd_mem = 1'b0;
		ctrl_o.wr_mem = 1'b0;
		ctrl_o.ldl_mem = 1'b0;
		ctrl_o.stc_mem = 1'b0;
		ctrl_o.cond_branch = 1'b0;
		ctrl_o.uncond_branch = 1'b0;
		ctrl_o.halt = 1'b0;
		ctrl_o.cpuid = 1'b0;
		ctrl_o.illegal = 1'b0;
		if (inst_valid_i)
		begin
			case (inst_i.op.opcode[5:3])	// block of eight opcodes
				3'h0:
				begin
					if (inst_i.pal.opcode != alpha_decode_pkg::PAL_INST)
						ctrl_o.illegal = 1'b1;	// only call_pal lives here
					else if (inst_i.pal.func == alpha_decode_pkg::PAL_HALT)
						ctrl_o.halt = 1'b1;
					else if (inst_i.pal.func == alpha_decode_pkg::PAL_WHAMI)
					begin
						ctrl_o.cpuid = 1'b1;
						ctrl_o.dest_sel = alpha_decode_pkg::DEST_IS_REGA;	// id lands in ra
					end
					else
						ctrl_o.illegal = 1'b1;	// other pal calls
				end
				3'h2:
				begin
					// ******************************
					// integer operate
					// ******************************
					ctrl_o.opa_sel = alpha_decode_pkg::OPA_IS_REGA;
					ctrl_o.opb_sel = inst_i.op.lit ? alpha_decode_pkg::OPB_IS_ALU_IMM :
						alpha_decode_pkg::OPB_IS_REGB;	// 8 bit literal form
					ctrl_o.dest_sel = alpha_decode_pkg::DEST_IS_REGC;
					case (inst_i.op.opcode)
						alpha_decode_pkg::INTA_GRP:
						begin
							ctrl_o.fu_sel = alpha_decode_pkg::FU_ALU;
							case (inst_i.op.func)
								alpha_decode_pkg::ADDQ: ctrl_o.alu_func = alpha_decode_pkg::ALU_ADDQ;
								alpha_decode_pkg::SUBQ: ctrl_o.alu_func = alpha_decode_pkg::ALU_SUBQ;
								alpha_decode_pkg::CMPEQ: ctrl_o.alu_func = alpha_decode_pkg::ALU_CMPEQ;
								alpha_decode_pkg::CMPLT: ctrl_o.alu_func = alpha_decode_pkg::ALU_CMPLT;
								alpha_decode_pkg::CMPLE: ctrl_o.alu_func = alpha_decode_pkg::ALU_CMPLE;
								alpha_decode_pkg::CMPULT:
									ctrl_o.alu_func = alpha_decode_pkg::ALU_CMPULT;
								alpha_decode_pkg::CMPULE:
									ctrl_o.alu_func = alpha_decode_pkg::ALU_CMPULE;
								default: ctrl_o.illegal = 1'b1;	// longword and overflow forms
							endcase
						end
						alpha_decode_pkg::INTL_GRP:
						begin
							ctrl_o.fu_sel = alpha_decode_pkg::FU_ALU;
							case (inst_i.op.func)
								alpha_decode_pkg::AND: ctrl_o.alu_func = alpha_decode_pkg::ALU_AND;
								alpha_decode_pkg::BIC: ctrl_o.alu_func = alpha_decode_pkg::ALU_BIC;
								alpha_decode_pkg::BIS: ctrl_o.alu_func = alpha_decode_pkg::ALU_BIS;
								alpha_decode_pkg::ORNOT: ctrl_o.alu_func = alpha_decode_pkg::ALU_ORNOT;
								alpha_decode_pkg::XOR: ctrl_o.alu_func = alpha_decode_pkg::ALU_XOR;
								alpha_decode_pkg::EQV: ctrl_o.alu_func = alpha_decode_pkg::ALU_EQV;
								default: ctrl_o.illegal = 1'b1;	// cmov and friends
							endcase
						end
						alpha_decode_pkg::INTS_GRP:
						begin
							ctrl_o.fu_sel = alpha_decode_pkg::FU_ALU;
							case (inst_i.op.func)
								alpha_decode_pkg::SRL: ctrl_o.alu_func = alpha_decode_pkg::ALU_SRL;
								alpha_decode_pkg::SLL: ctrl_o.alu_func = alpha_decode_pkg::ALU_SLL;
								alpha_decode_pkg::SRA: ctrl_o.alu_func = alpha_decode_pkg::ALU_SRA;
								default: ctrl_o.illegal = 1'b1;	// byte manipulation
							endcase
						end
						alpha_decode_pkg::INTM_GRP:
						begin
							ctrl_o.fu_sel = alpha_decode_pkg::FU_MULT;
							if (inst_i.op.func == alpha_decode_pkg::MULQ)
								ctrl_o.alu_func = alpha_decode_pkg::ALU_MULQ;
							else
								ctrl_o.illegal = 1'b1;	// mull, umulh
						end
						default: ctrl_o.illegal = 1'b1;	// fp operate groups
					endcase
				end
				3'h3:
				begin
					if (inst_i.op.opcode == alpha_decode_pkg::JSR_GRP)
					begin
						// all four jump hints behave the same
						ctrl_o.opa_sel = alpha_decode_pkg::OPA_IS_NOT3;
						ctrl_o.opb_sel = alpha_decode_pkg::OPB_IS_REGB;	// target in rb
						ctrl_o.alu_func = alpha_decode_pkg::ALU_AND;	// word align target
						ctrl_o.dest_sel = alpha_decode_pkg::DEST_IS_REGA;	// return address
						ctrl_o.uncond_branch = 1'b1;
						ctrl_o.fu_sel = alpha_decode_pkg::FU_UNCOND_BRANCH;
					end
					else
						ctrl_o.illegal = 1'b1;	// misc and fp transfer groups
				end
				3'h1, 3'h4, 3'h5:
				begin
					// ******************************
					// memory format
					// ******************************
					ctrl_o.opa_sel = alpha_decode_pkg::OPA_IS_MEM_DISP;
					ctrl_o.opb_sel = alpha_decode_pkg::OPB_IS_REGB;	// base register
					ctrl_o.alu_func = alpha_decode_pkg::ALU_ADDQ;	// base plus disp
					ctrl_o.dest_sel = alpha_decode_pkg::DEST_IS_REGA;
					case (inst_i.mem.opcode)
						alpha_decode_pkg::LDA_INST: ctrl_o.fu_sel = alpha_decode_pkg::FU_ALU;
						alpha_decode_pkg::LDQ_INST:
						begin
							ctrl_o.rd_mem = 1'b1;
							ctrl_o.fu_sel = alpha_decode_pkg::FU_LOAD;
						end
						alpha_decode_pkg::LDQ_L_INST:
						begin
							ctrl_o.rd_mem = 1'b1;
							ctrl_o.ldl_mem = 1'b1;	// sets the lock flag
							ctrl_o.fu_sel = alpha_decode_pkg::FU_LOAD;
						end
						alpha_decode_pkg::STQ_INST:
						begin
							ctrl_o.wr_mem = 1'b1;
							ctrl_o.dest_sel = alpha_decode_pkg::DEST_NONE;	// ra is data only
							ctrl_o.fu_sel = alpha_decode_pkg::FU_STORE;
						end
						alpha_decode_pkg::STQ_C_INST:
						begin
							ctrl_o.wr_mem = 1'b1;
							ctrl_o.stc_mem = 1'b1;	// success flag back to ra
							ctrl_o.fu_sel = alpha_decode_pkg::FU_STORE;
						end
						default: ctrl_o.illegal = 1'b1;	// ldah, byte and fp memory ops
					endcase
				end
				default:
				begin
					// branch format, blocks 6 and 7
					ctrl_o.opa_sel = alpha_decode_pkg::OPA_IS_REGA;	// compare operand
					ctrl_o.opb_sel = alpha_decode_pkg::OPB_IS_BR_DISP;
					ctrl_o.alu_func = alpha_decode_pkg::ALU_ADDQ;	// target pc
					case (inst_i.br.opcode)
						alpha_decode_pkg::FBEQ, alpha_decode_pkg::FBLT, alpha_decode_pkg::FBLE,
						alpha_decode_pkg::FBNE, alpha_decode_pkg::FBGE, alpha_decode_pkg::FBGT:
							ctrl_o.illegal = 1'b1;	// no fp register file
						alpha_decode_pkg::BR_INST, alpha_decode_pkg::BSR_INST:
						begin
							ctrl_o.dest_sel = alpha_decode_pkg::DEST_IS_REGA;	// link
							ctrl_o.uncond_branch = 1'b1;
							ctrl_o.fu_sel = alpha_decode_pkg::FU_UNCOND_BRANCH;
						end
						default:
						begin
							ctrl_o.cond_branch = 1'b1;	// blbc through bgt
							ctrl_o.fu_sel = alpha_decode_pkg::FU_COND_BRANCH;
						end
					endcase
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/alpha_decode_pkg.sv
// covers the alpha integer subset only and gives floating point opcodes no encoding of their own
`default_nettype none

package alpha_decode_pkg;

	// ******************************
	// major opcodes and pal functions
	// ******************************
	localparam logic [5:0] PAL_INST = 6'h00;
	localparam logic [25:0] PAL_HALT = 26'h555;	// pal function for halt
	localparam logic [25:0] PAL_WHAMI = 26'h03c;	// pal function for cpuid read

	localparam logic [5:0] LDA_INST = 6'h08;	// address calc only
	localparam logic [5:0] INTA_GRP = 6'h10;	// add, sub, compares
	localparam logic [5:0] INTL_GRP = 6'h11;	// logicals
	localparam logic [5:0] INTS_GRP = 6'h12;	// shifts
	localparam logic [5:0] INTM_GRP = 6'h13;	// multiply
	localparam logic [5:0] JSR_GRP = 6'h1a;	// jmp, jsr, ret, jsr_co
	localparam logic [5:0] LDQ_INST = 6'h29;
	localparam logic [5:0] LDQ_L_INST = 6'h2b;	// load locked
	localparam logic [5:0] STQ_INST = 6'h2d;
	localparam logic [5:0] STQ_C_INST = 6'h2f;	// store conditional
	localparam logic [5:0] BR_INST = 6'h30;
	localparam logic [5:0] BSR_INST = 6'h34;

	// fp conditional branches share the branch block
	localparam logic [5:0] FBEQ = 6'h31;
	localparam logic [5:0] FBLT = 6'h32;
	localparam logic [5:0] FBLE = 6'h33;
	localparam logic [5:0] FBNE = 6'h35;
	localparam logic [5:0] FBGE = 6'h36;
	localparam logic [5:0] FBGT = 6'h37;

	// ******************************
	// operate function codes
	// ******************************
	localparam logic [6:0] ADDQ = 7'h20;	// inta
	localparam logic [6:0] SUBQ = 7'h29;
	localparam logic [6:0] CMPEQ = 7'h2d;
	localparam logic [6:0] CMPLT = 7'h4d;
	localparam logic [6:0] CMPLE = 7'h6d;
	localparam logic [6:0] CMPULT = 7'h1d;
	localparam logic [6:0] CMPULE = 7'h3d;
	localparam logic [6:0] AND = 7'h00;	// intl
	localparam logic [6:0] BIC = 7'h08;
	localparam logic [6:0] BIS = 7'h20;
	localparam logic [6:0] ORNOT = 7'h28;
	localparam logic [6:0] XOR = 7'h40;
	localparam logic [6:0] EQV = 7'h48;
	localparam logic [6:0] SRL = 7'h34;	// ints
	localparam logic [6:0] SLL = 7'h39;
	localparam logic [6:0] SRA = 7'h3c;
	localparam logic [6:0] MULQ = 7'h20;	// intm

	localparam logic [4:0] ZERO_REG = 5'd31;	// r31 reads zero, writes dropped
	localparam int VCOUNT_W = 16;	// valid instruction counter width

	// ******************************
	// selects, functions, units
	// ******************************
	typedef enum logic [1:0] {
		OPA_IS_REGA = 2'h0,
		OPA_IS_MEM_DISP = 2'h1,
		OPA_IS_NOT3 = 2'h2	// constant ~3 for jump alignment
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_IS_REGB = 2'h0,
		OPB_IS_ALU_IMM = 2'h1,
		OPB_IS_BR_DISP = 2'h2
	} opb_sel_e;

	typedef enum logic [1:0] {
		DEST_NONE = 2'h0,
		DEST_IS_REGA = 2'h1,
		DEST_IS_REGC = 2'h2
	} dest_sel_e;

	typedef enum logic [4:0] {
		ALU_ADDQ = 5'h00,	// also the noop value
		ALU_SUBQ = 5'h01,
		ALU_AND = 5'h02,
		ALU_BIC = 5'h03,
		ALU_BIS = 5'h04,
		ALU_ORNOT = 5'h05,
		ALU_XOR = 5'h06,
		ALU_EQV = 5'h07,
		ALU_SRL = 5'h08,
		ALU_SLL = 5'h09,
		ALU_SRA = 5'h0a,
		ALU_MULQ = 5'h0b,
		ALU_CMPULT = 5'h0c,
		ALU_CMPEQ = 5'h0d,
		ALU_CMPULE = 5'h0e,
		ALU_CMPLT = 5'h0f,
		ALU_CMPLE = 5'h10
	} alu_func_e;

	typedef enum logic [2:0] {
		FU_NONE = 3'h0,
		FU_ALU = 3'h1,
		FU_MULT = 3'h2,
		FU_LOAD = 3'h3,
		FU_STORE = 3'h4,
		FU_COND_BRANCH = 3'h5,
		FU_UNCOND_BRANCH = 3'h6
	} fu_sel_e;

	// ******************************
	// instruction formats
	// ******************************
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;	// upper literal bits when lit set
		logic [2:0] lit_lo;	// low literal bits, sbz otherwise
		logic lit;	// literal form of operand b
		logic [6:0] func;
		logic [4:0] rc;
	} op_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [15:0] disp;
	} mem_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] ra;
		logic [20:0] disp;	// word displacement
	} br_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] func;
	} pal_fmt_t;

	typedef union packed {
		op_fmt_t op;
		mem_fmt_t mem;
		br_fmt_t br;
		pal_fmt_t pal;
	} alpha_inst_u;

	// decoder to id stage
	typedef struct packed {
		opa_sel_e opa_sel;
		opb_sel_e opb_sel;
		dest_sel_e dest_sel;
		alu_func_e alu_func;
		fu_sel_e fu_sel;
		logic rd_mem;
		logic wr_mem;
		logic ldl_mem;
		logic stc_mem;
		logic cond_branch;
		logic uncond_branch;
		logic halt;
		logic cpuid;
		logic illegal;
	} dec_ctrl_t;

	// id stage to id/ex and beyond
	typedef struct packed {
		alpha_inst_u ir;
		logic [4:0] ra_idx;
		logic [4:0] rb_idx;
		logic [4:0] dest_idx;
		fu_sel_e fu_sel;
		alu_func_e alu_func;
		logic rd_mem;
		logic wr_mem;
		logic ldl_mem;
		logic stc_mem;
		logic cond_branch;
		logic uncond_branch;
		logic halt;
		logic cpuid;
		logic illegal;
		logic valid_inst;
	} id_packet_t;

	// bubble value of the id/ex register
	localparam id_packet_t ID_NOOP = '{
		ir: '0,
		ra_idx: ZERO_REG,
		rb_idx: ZERO_REG,
		dest_idx: ZERO_REG,
		fu_sel: FU_NONE,
		alu_func: ALU_ADDQ,
		default: 1'b0
	};

endpackage

`default_nettype wire
